// ==== Makefile ====
# Verilator build and run of the normalization engine testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= norm_tb
SEED      ?= 63
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

# build, run, then fail unless the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) -f vlog.f --top-module $(TOP) -GSEED=$(SEED) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/lzc.sv ====
/*
 * leading or trailing zero counter
 * MODE 0 counts zeros from the LSB, MODE 1 counts zeros from the MSB
 * empty_o flags an all-zero input, the count is then WIDTH minus one
 */

module lzc #(
  parameter int unsigned WIDTH     = 2,
  // 0 gives the trailing count, 1 the leading count
  parameter bit          MODE      = 1'b0,
  // derived from WIDTH, left at its default
  parameter int unsigned CNT_WIDTH = (WIDTH == 1) ? 1 : $clog2(WIDTH)
) (
  input  logic [WIDTH-1:0]     in_i,
  output logic [CNT_WIDTH-1:0] cnt_o,
  output logic                 empty_o
);

  if (WIDTH == 1) begin : gen_single_bit

    // a lone bit never has zeros in front of it
    assign cnt_o   = '0;
    assign empty_o = ~in_i[0];

  end else begin : gen_tree

    localparam int unsigned LEVELS = $clog2(WIDTH);
    // the tree is stored as a heap, node 0 is the root
    localparam int unsigned NODES  = 2**LEVELS - 1;

    logic [WIDTH-1:0]             in_ord;
    logic [NODES-1:0]             node_sel;
    logic [NODES-1:0][LEVELS-1:0] node_idx;

    // in leading mode the input is mirrored so that the search
    // always looks for the lowest set bit
    always_comb begin : reorder
      for (int unsigned i = 0; i < WIDTH; i++) begin
        in_ord[i] = MODE ? in_i[WIDTH-1-i] : in_i[i];
      end
    end

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : gen_level
      localparam int unsigned BASE  = 2**lvl - 1;
      localparam int unsigned CHILD = 2**(lvl+1) - 1;

      for (genvar n = 0; n < 2**lvl; n++) begin : gen_node
        if (lvl == LEVELS-1) begin : gen_leaf
          localparam int unsigned LO = 2 * n;

          // the bottom level looks straight at pairs of input bits
          if (LO + 1 < WIDTH) begin : gen_pair
            assign node_sel[BASE+n] = in_ord[LO] | in_ord[LO+1];
            assign node_idx[BASE+n] = in_ord[LO] ? LEVELS'(LO) : LEVELS'(LO + 1);
          end else if (LO < WIDTH) begin : gen_single
            // odd width leaves one bit without a partner
            assign node_sel[BASE+n] = in_ord[LO];
            assign node_idx[BASE+n] = LEVELS'(LO);
          end else begin : gen_pad
            // padding beyond the input never wins
            assign node_sel[BASE+n] = 1'b0;
            assign node_idx[BASE+n] = '0;
          end
        end else begin : gen_inner
          // the lower half wins whenever it holds a set bit
          assign node_sel[BASE+n] = node_sel[CHILD+2*n] | node_sel[CHILD+2*n+1];
          assign node_idx[BASE+n] = node_sel[CHILD+2*n] ? node_idx[CHILD+2*n]
                                                        : node_idx[CHILD+2*n+1];
        end
      end
    end

    // the root carries the index of the first set bit
    assign cnt_o   = node_idx[0];
    assign empty_o = ~node_sel[0];

  end

endmodule

// ==== logic/norm_apb_regs.sv ====
/*
 * APB register block of the normalization engine
 * holds CTRL, issues a request per OPERAND write, captures the
 * response into RESULT and STATUS and raises done until RESULT is read
 */

`include "norm_defs.svh"

module norm_apb_regs (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  norm_pkg::apb_req_t  apb_req_i,
  output norm_pkg::apb_rsp_t  apb_rsp_o,
  output norm_pkg::norm_req_t req_o,
  input  norm_pkg::norm_rsp_t rsp_i,
  output logic                done_irq_o
);

  import norm_pkg::*;

  logic                    access;
  logic                    hit_ctrl;
  logic                    hit_operand;
  logic                    hit_result;
  logic                    hit_status;
  logic                    wr_ok;
  logic                    rd_ok;
  logic                    err;
  logic                    wr_acc;
  logic                    rd_acc;

  logic                    mode_q;
  norm_req_t               req_q;
  logic [`NORM_DATA_W-1:0] result_q;
  logic [`NORM_CNT_W-1:0]  count_q;
  logic                    zero_q;
  logic                    done_q;
  logic [1:0]              outst_q;
  logic                    busy;
  logic [`NORM_DATA_W-1:0] status_word;
  logic [`NORM_DATA_W-1:0] rdata;

  // the transfer completes in the access phase since pready is tied high
  assign access = apb_req_i.psel & apb_req_i.penable;

  // full address decode, so unaligned offsets fall through as unmapped
  assign hit_ctrl    = (apb_req_i.paddr == `NORM_REG_CTRL);
  assign hit_operand = (apb_req_i.paddr == `NORM_REG_OPERAND);
  assign hit_result  = (apb_req_i.paddr == `NORM_REG_RESULT);
  assign hit_status  = (apb_req_i.paddr == `NORM_REG_STATUS);

  // OPERAND is write-only, RESULT and STATUS are read-only
  assign wr_ok = hit_ctrl | hit_operand;
  assign rd_ok = hit_ctrl | hit_result | hit_status;
  assign err   = apb_req_i.pwrite ? ~wr_ok : ~rd_ok;

  // a rejected access touches no state
  assign wr_acc = access & apb_req_i.pwrite & ~err;
  assign rd_acc = access & ~apb_req_i.pwrite & ~err;

  // CTRL bit 0 selects leading or trailing mode
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mode_q <= 1'b0;
    end else if (wr_acc && hit_ctrl) begin
      mode_q <= apb_req_i.pwdata[0];
    end
  end

  // the request valid is a single cycle pulse right after the OPERAND write
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q.valid <= 1'b0;
    end else begin
      req_q.valid <= wr_acc & hit_operand;
    end
  end

  // the mode is sampled from CTRL at the time of the write
  always_ff @(posedge clk_i) begin
    if (wr_acc && hit_operand) begin
      req_q.mode    <= mode_q;
      req_q.operand <= apb_req_i.pwdata;
    end
  end

  assign req_o = req_q;

  // the newest response always overwrites the previous one
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_q <= '0;
      count_q  <= '0;
      zero_q   <= 1'b0;
    end else if (rsp_i.valid) begin
      result_q <= rsp_i.result;
      count_q  <= rsp_i.count;
      zero_q   <= rsp_i.zero;
    end
  end

  // a response arriving with a RESULT read keeps done set
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else if (rsp_i.valid) begin
      done_q <= 1'b1;
    end else if (rd_acc && hit_result) begin
      done_q <= 1'b0;
    end
  end

  // requests in flight, the pipeline holds at most two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outst_q <= 2'd0;
    end else begin
      case ({req_q.valid, rsp_i.valid})
        2'b10:   outst_q <= outst_q + 2'd1;
        2'b01:   outst_q <= outst_q - 2'd1;
        default: outst_q <= outst_q;
      endcase
    end
  end

  // busy already covers the issue cycle, before the counter moves
  assign busy = req_q.valid | (outst_q != 2'd0);

  assign status_word = {19'd0, count_q, 5'd0, busy, zero_q, done_q};

  // read data is driven only for an accepted read
  always_comb begin
    rdata = '0;
    if (rd_acc) begin
      if (hit_ctrl) begin
        rdata = {{(`NORM_DATA_W-1){1'b0}}, mode_q};
      end else if (hit_result) begin
        rdata = result_q;
      end else if (hit_status) begin
        rdata = status_word;
      end
    end
  end

  always_comb begin
    apb_rsp_o.prdata  = rdata;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = access & err;
  end

  // the interrupt line mirrors the done bit
  assign done_irq_o = done_q;

endmodule

// ==== logic/norm_defs.svh ====
/*
 * normalization engine shared constants
 * data, count and APB address widths plus the register map offsets
 */

`ifndef NORM_DEFS_SVH
`define NORM_DEFS_SVH

// operand and result width in bits
`define NORM_DATA_W 32

// zero count width, enough to index every bit of the operand
`define NORM_CNT_W 5

// APB address width, the register map spans four 32-bit words
`define NORM_ADDR_W 4

// register offsets, sized to the APB address width
`define NORM_REG_CTRL    4'h0
`define NORM_REG_OPERAND 4'h4
`define NORM_REG_RESULT  4'h8
`define NORM_REG_STATUS  4'hC

`endif

// ==== logic/norm_pkg.sv ====
/*
 * normalization engine types
 * APB request and response bundles and the request and response
 * structs passed between the register block and the shift pipeline
 */

`include "norm_defs.svh"

package norm_pkg;

  // signals driven by the APB master
  typedef struct packed {
    logic [`NORM_ADDR_W-1:0] paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`NORM_DATA_W-1:0] pwdata;
  } apb_req_t;

  // signals returned by the slave, pready stays high since there are no wait states
  typedef struct packed {
    logic [`NORM_DATA_W-1:0] prdata;
    logic                    pready;
    logic                    pslverr;
  } apb_rsp_t;

  // one normalization job, mode 0 counts leading zeros and 1 trailing zeros
  typedef struct packed {
    logic                    valid;
    logic                    mode;
    logic [`NORM_DATA_W-1:0] operand;
  } norm_req_t;

  // finished job, zero marks an all-zero operand
  typedef struct packed {
    logic                    valid;
    logic [`NORM_DATA_W-1:0] result;
    logic [`NORM_CNT_W-1:0]  count;
    logic                    zero;
  } norm_rsp_t;

endpackage

// ==== logic/norm_shift_pipe.sv ====
/*
 * two stage normalization pipeline
 * stage 1 counts the zeros on the side chosen by the mode
 * stage 2 shifts the operand by that count and presents the response
 */

`include "norm_defs.svh"

module norm_shift_pipe (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  norm_pkg::norm_req_t req_i,
  output norm_pkg::norm_rsp_t rsp_o
);

  import norm_pkg::*;

  logic [`NORM_CNT_W-1:0]  lead_cnt;
  logic [`NORM_CNT_W-1:0]  trail_cnt;
  logic                    lead_empty;
  logic [`NORM_CNT_W-1:0]  cnt_sel;

  logic                    s1_valid_q;
  logic                    s1_mode_q;
  logic [`NORM_DATA_W-1:0] s1_operand_q;
  logic [`NORM_CNT_W-1:0]  s1_cnt_q;
  logic                    s1_empty_q;

  logic [`NORM_DATA_W-1:0] shifted;
  norm_rsp_t               rsp_q;

  // leading zeros drive the left shift
  lzc #(
    .WIDTH (`NORM_DATA_W),
    .MODE  (1'b1)
  ) u_lzc_lead (
    .in_i    (req_i.operand),
    .cnt_o   (lead_cnt),
    .empty_o (lead_empty)
  );

  // trailing zeros drive the right shift
  lzc #(
    .WIDTH (`NORM_DATA_W),
    .MODE  (1'b0)
  ) u_lzc_trail (
    .in_i    (req_i.operand),
    .cnt_o   (trail_cnt),
    .empty_o ()
  );

  // mode 0 is leading, mode 1 is trailing
  assign cnt_sel = req_i.mode ? trail_cnt : lead_cnt;

  // each stage valid follows the one before it
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q  <= 1'b0;
      rsp_q.valid <= 1'b0;
    end else begin
      s1_valid_q  <= req_i.valid;
      rsp_q.valid <= s1_valid_q;
    end
  end

  // stage 1 holds the operand alongside its count
  // an all-zero operand is flagged the same way by either counter
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      s1_mode_q    <= req_i.mode;
      s1_operand_q <= req_i.operand;
      s1_cnt_q     <= cnt_sel;
      s1_empty_q   <= lead_empty;
    end
  end

  // left shift puts the top set bit at the MSB, right shift puts the
  // lowest set bit at bit 0
  assign shifted = s1_mode_q ? (s1_operand_q >> s1_cnt_q)
                             : (s1_operand_q << s1_cnt_q);

  // a zero operand reports count 0 instead of the counter's WIDTH minus one
  always_ff @(posedge clk_i) begin
    if (s1_valid_q) begin
      rsp_q.result <= s1_empty_q ? '0 : shifted;
      rsp_q.count  <= s1_empty_q ? '0 : s1_cnt_q;
      rsp_q.zero   <= s1_empty_q;
    end
  end

  assign rsp_o = rsp_q;

endmodule

// ==== logic/norm_top.sv ====
/*
 * normalization engine top level
 * the APB register block feeds the two stage shift pipeline and
 * collects its responses
 */

module norm_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  norm_pkg::apb_req_t apb_req_i,
  output norm_pkg::apb_rsp_t apb_rsp_o,
  output logic               done_irq_o
);

  import norm_pkg::*;

  // request toward the pipeline, one pulse per OPERAND write
  norm_req_t norm_req;
  // response back into the register block after two cycles
  norm_rsp_t norm_rsp;

  // register block decodes APB and owns all software visible state
  norm_apb_regs u_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .req_o      (norm_req),
    .rsp_i      (norm_rsp),
    .done_irq_o (done_irq_o)
  );

  // the pipeline takes every request, there is no back-pressure
  norm_shift_pipe u_pipe (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (norm_req),
    .rsp_o   (norm_rsp)
  );

endmodule

// ==== tb/norm_asserts.sv ====
/*
 * concurrent assertions on the normalization register block
 * APB ready and error timing, done after reset, request pulse width
 */

module norm_asserts (
  input logic                clk_i,
  input logic                rst_n_i,
  input norm_pkg::apb_req_t  apb_req_i,
  input norm_pkg::apb_rsp_t  apb_rsp_i,
  input norm_pkg::norm_req_t req_i,
  input logic                done_irq_i
);

  // failed assertions are tallied here and read by the testbench at the end
  int unsigned fail_cnt = 0;

  // the block inserts no wait states
  pready_high: assert property (@(posedge clk_i) apb_rsp_i.pready)
    else begin
      $error("pready went low");
      fail_cnt++;
    end

  // an error response only makes sense while a transfer completes
  slverr_in_access: assert property (@(posedge clk_i)
      apb_rsp_i.pslverr |-> (apb_req_i.psel && apb_req_i.penable))
    else begin
      $error("pslverr raised outside an access phase");
      fail_cnt++;
    end

  // done comes out of reset cleared
  done_low_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !done_irq_i)
    else begin
      $error("done_irq_o high in the first cycle after reset");
      fail_cnt++;
    end

  // each OPERAND write issues exactly one request cycle
  req_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_i.valid |=> !req_i.valid)
    else begin
      $error("request valid held for more than one cycle");
      fail_cnt++;
    end

endmodule

bind norm_apb_regs norm_asserts u_asserts (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .apb_req_i  (apb_req_i),
  .apb_rsp_i  (apb_rsp_o),
  .req_i      (req_o),
  .done_irq_i (done_irq_o)
);

// ==== tb/norm_tb.sv ====
/*
 * testbench for the normalization engine
 * applies a table of leading and trailing mode operands over APB,
 * checks result, status and done timing, then the error responses
 */

`include "norm_defs.svh"

module norm_tb #(
  parameter int unsigned SEED = 63
);

  import norm_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int NUM_FIXED       = 12;
  localparam int NUM_RAND        = 16;
  localparam int NUM_TESTS       = NUM_FIXED + NUM_RAND;
  localparam int DONE_LIMIT      = 10;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 20 + 200;

  logic     clk_i;
  logic     rst_n_i;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     done_irq;

  int unsigned errors;

  // stimulus table, one index per test across all arrays
  string                   tbl_name [NUM_TESTS];
  logic                    tbl_mode [NUM_TESTS];
  logic [`NORM_DATA_W-1:0] tbl_op   [NUM_TESTS];
  logic [`NORM_DATA_W-1:0] tbl_res  [NUM_TESTS];
  logic [`NORM_CNT_W-1:0]  tbl_cnt  [NUM_TESTS];
  logic                    tbl_zero [NUM_TESTS];

  norm_top u_norm_top (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .done_irq_o (done_irq)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  // setup phase on one falling edge, access on the next, sampled mid low phase
  task automatic apb_write(input logic [`NORM_ADDR_W-1:0] addr,
                           input logic [`NORM_DATA_W-1:0] data, output logic slverr);
    @(negedge clk_i);
    apb_req.paddr   = addr;
    apb_req.pwrite  = 1'b1;
    apb_req.pwdata  = data;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    #(CLK_PERIOD / 4);
    slverr = apb_rsp.pslverr;
    @(negedge clk_i);
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [`NORM_ADDR_W-1:0] addr,
                          output logic [`NORM_DATA_W-1:0] data, output logic slverr);
    @(negedge clk_i);
    apb_req.paddr   = addr;
    apb_req.pwrite  = 1'b0;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    #(CLK_PERIOD / 4);
    data   = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk_i);
    apb_req = '0;
  endtask

  // zeros counted from the MSB in mode 0 and from the LSB in mode 1, 32 when all zero
  function automatic int count_zeros(input logic mode, input logic [`NORM_DATA_W-1:0] op);
    int n;
    n = 0;
    while (n < `NORM_DATA_W && !(mode ? op[n] : op[`NORM_DATA_W-1-n])) begin
      n++;
    end
    return n;
  endfunction

  task automatic set_entry(input int idx, input string name, input logic mode,
                           input logic [31:0] op, input logic [31:0] res,
                           input logic [4:0] cnt, input logic zero);
    tbl_name[idx] = name;
    tbl_mode[idx] = mode;
    tbl_op[idx]   = op;
    tbl_res[idx]  = res;
    tbl_cnt[idx]  = cnt;
    tbl_zero[idx] = zero;
  endtask

  task automatic fill_table();
    logic        mode;
    logic [31:0] raw;
    logic [31:0] op;
    logic [31:0] res;
    int          cnt;
    int unsigned sh;
    logic        zero;
    // mode 0 is leading, mode 1 trailing
    set_entry(0, "lead_bit12", 1'b0, 32'h0000_1000, 32'h8000_0000, 5'd19, 1'b0);
    set_entry(1, "trail_bit12", 1'b1, 32'h0000_1000, 32'h0000_0001, 5'd12, 1'b0);
    set_entry(2, "lead_zero", 1'b0, 32'h0000_0000, 32'h0000_0000, 5'd0, 1'b1);
    set_entry(3, "trail_zero", 1'b1, 32'h0000_0000, 32'h0000_0000, 5'd0, 1'b1);
    set_entry(4, "lead_msb_set", 1'b0, 32'h8000_0001, 32'h8000_0001, 5'd0, 1'b0);
    set_entry(5, "trail_lsb_set", 1'b1, 32'h8000_0001, 32'h8000_0001, 5'd0, 1'b0);
    set_entry(6, "lead_one", 1'b0, 32'h0000_0001, 32'h8000_0000, 5'd31, 1'b0);
    set_entry(7, "trail_msb_only", 1'b1, 32'h8000_0000, 32'h0000_0001, 5'd31, 1'b0);
    set_entry(8, "lead_mixed", 1'b0, 32'h0003_5A00, 32'hD680_0000, 5'd14, 1'b0);
    set_entry(9, "trail_mixed", 1'b1, 32'h0003_5A00, 32'h0000_01AD, 5'd9, 1'b0);
    set_entry(10, "lead_all_ones", 1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd0, 1'b0);
    set_entry(11, "trail_nibble", 1'b1, 32'h00F0_0000, 32'h0000_000F, 5'd20, 1'b0);
    // random operands are pre-shifted so the counts spread over the whole range
    for (int i = NUM_FIXED; i < NUM_TESTS; i++) begin
      mode = 1'($urandom_range(1, 0));
      raw  = $urandom();
      sh   = $urandom_range(31, 0);
      op   = mode ? (raw << sh) : (raw >> sh);
      cnt  = count_zeros(mode, op);
      zero = (cnt == `NORM_DATA_W);
      res  = mode ? (op >> cnt) : (op << cnt);
      if (zero) begin
        res = '0;
        cnt = 0;
      end
      set_entry(i, $sformatf("rand_%0d", i - NUM_FIXED), mode, op, res, 5'(cnt), zero);
    end
  endtask

  task automatic check_reset();
    logic                    err;
    logic [`NORM_DATA_W-1:0] rdata;
    check_val("reset_done_irq", 32'd0, 32'(done_irq));
    apb_read(`NORM_REG_STATUS, rdata, err);
    check_val("reset_status_err", 32'd0, 32'(err));
    check_val("reset_status", 32'd0, rdata);
    apb_read(`NORM_REG_RESULT, rdata, err);
    check_val("reset_result_err", 32'd0, 32'(err));
    check_val("reset_result", 32'd0, rdata);
    apb_read(`NORM_REG_CTRL, rdata, err);
    check_val("reset_ctrl_err", 32'd0, 32'(err));
    check_val("reset_ctrl", 32'd0, rdata);
  endtask

  task automatic run_entry(input int idx);
    logic                    err;
    logic [`NORM_DATA_W-1:0] rdata;
    logic [`NORM_DATA_W-1:0] exp_status;
    int                      cycles;
    string                   name;
    name       = tbl_name[idx];
    // done set, busy clear, count in bits 12 to 8
    exp_status = {19'd0, tbl_cnt[idx], 5'd0, 1'b0, tbl_zero[idx], 1'b1};
    apb_write(`NORM_REG_CTRL, {31'd0, tbl_mode[idx]}, err);
    check_val({name, "_ctrl_err"}, 32'd0, 32'(err));
    apb_read(`NORM_REG_CTRL, rdata, err);
    check_val({name, "_ctrl"}, {31'd0, tbl_mode[idx]}, rdata);
    apb_write(`NORM_REG_OPERAND, tbl_op[idx], err);
    check_val({name, "_operand_err"}, 32'd0, 32'(err));
    // the write task returns one falling edge after the access ends
    check_val({name, "_done_early"}, 32'd0, 32'(done_irq));
    cycles = 0;
    while (!done_irq && cycles < DONE_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!done_irq) begin
      errors++;
      $display("%s: done_irq_o never rose after the operand write", name);
    end else begin
      check_val({name, "_latency"}, 32'd3, 32'(cycles));
    end
    apb_read(`NORM_REG_STATUS, rdata, err);
    check_val({name, "_status"}, exp_status, rdata);
    apb_read(`NORM_REG_RESULT, rdata, err);
    check_val({name, "_result"}, tbl_res[idx], rdata);
    check_val({name, "_done_cleared"}, 32'd0, 32'(done_irq));
  endtask

  task automatic check_errors();
    logic                    err;
    logic [`NORM_DATA_W-1:0] rdata;
    // the 4-bit paddr folds 0x10 onto CTRL, so 0x6 reaches the unmapped decode
    apb_write(4'h6, 32'hDEAD_BEEF, err);
    check_val("unmapped_write_err", 32'd1, 32'(err));
    apb_read(4'h6, rdata, err);
    check_val("unmapped_read_err", 32'd1, 32'(err));
    apb_write(`NORM_REG_STATUS, 32'hFFFF_FFFF, err);
    check_val("status_write_err", 32'd1, 32'(err));
    apb_write(`NORM_REG_RESULT, 32'h1234_5678, err);
    check_val("result_write_err", 32'd1, 32'(err));
    apb_read(`NORM_REG_OPERAND, rdata, err);
    check_val("operand_read_err", 32'd1, 32'(err));
    // rejected accesses must leave every register alone
    apb_read(`NORM_REG_RESULT, rdata, err);
    check_val("result_kept_err", 32'd0, 32'(err));
    check_val("result_kept", tbl_res[NUM_TESTS-1], rdata);
    apb_read(`NORM_REG_CTRL, rdata, err);
    check_val("ctrl_kept", {31'd0, tbl_mode[NUM_TESTS-1]}, rdata);
    check_val("done_kept_low", 32'd0, 32'(done_irq));
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : main
    int unsigned total;
    clk_i   = 1'b0;
    rst_n_i = 1'b0;
    apb_req = '0;
    errors  = 0;
    void'($urandom(SEED));
    fill_table();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    check_reset();
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_entry(i);
    end
    check_errors();
    total = errors + u_norm_top.u_regs.u_asserts.fail_cnt;
    $display("checks failed: %0d, assertions failed: %0d", errors,
             u_norm_top.u_regs.u_asserts.fail_cnt);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/norm_pkg.sv
logic/lzc.sv
logic/norm_shift_pipe.sv
logic/norm_apb_regs.sv
logic/norm_top.sv
tb/norm_asserts.sv
tb/norm_tb.sv
